/* include/slice_params.svh */
// integer slice sizing: data width, register count and issue queue depth
`ifndef SLICE_PARAMS_SVH
`define SLICE_PARAMS_SVH

// data and pc width
`define SLICE_XLEN 32

// architectural register file
`define SLICE_NREGS 32
`define SLICE_RIDX 5

// issue queue entries
`define SLICE_IQ_DEPTH 4

`endif

/* logic/uop_pkg.sv */
// front-end types of the integer slice: fetch packet, alu opcodes and micro-op
`include "slice_params.svh"

package uop_pkg;

    // instruction word and its pc as fetched
    typedef struct packed {
        logic [31:0]             instr;
        logic [`SLICE_XLEN-1:0]  pc;
    } fetch_t;

    // low three bits follow funct3, bit 3 is the funct7 alternate form
    typedef enum logic [3:0] {
        op_add  = 4'b0000,
        op_sll  = 4'b0001,
        op_slt  = 4'b0010,
        op_sltu = 4'b0011,
        op_xor  = 4'b0100,
        op_srl  = 4'b0101,
        op_or   = 4'b0110,
        op_and  = 4'b0111,
        op_sub  = 4'b1000,
        op_sra  = 4'b1101
    } alu_op_e;

    // operand b is rs2 or the extended immediate
    typedef struct packed {
        alu_op_e                 op;
        logic [`SLICE_RIDX-1:0]  rd;
        logic [`SLICE_XLEN-1:0]  a;
        logic [`SLICE_XLEN-1:0]  b;
        logic                    writes_rd;
        logic [`SLICE_XLEN-1:0]  pc;
    } uop_t;

endpackage

/* logic/commit_pkg.sv */
// back-end types of the integer slice: the result presented at commit
`include "slice_params.svh"

package commit_pkg;

    // one committed alu result
    typedef struct packed {
        logic [`SLICE_XLEN-1:0]  pc;
        logic [`SLICE_RIDX-1:0]  rd;
        logic                    writes_rd;
        logic [`SLICE_XLEN-1:0]  value;
    } result_t;

endpackage

/* logic/ifid_stage.sv */
// if/id pipeline register, one entry with stall hold and flush to empty
`timescale 1ns/1ns

module ifid_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            fetch_valid,
    output logic            fetch_ready,
    input  uop_pkg::fetch_t fetch,
    output logic            ifid_valid,
    input  logic            ifid_ready,
    output uop_pkg::fetch_t ifid
);

    logic load;

    // free when empty or when the held packet leaves this cycle
    assign fetch_ready = !ifid_valid || ifid_ready;
    assign load        = fetch_valid && fetch_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifid_valid <= 1'b0;
        end else if (flush) begin
            ifid_valid <= 1'b0;
        end else if (load) begin
            ifid_valid <= 1'b1;
        end else if (ifid_ready) begin
            ifid_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ifid <= fetch;
        end
    end

endmodule

/* logic/decode_stage.sv */
// decode stage: rv32i op/op-imm decoder, register file and busy-bit scoreboard
`timescale 1ns/1ns
`include "slice_params.svh"

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                ifid_valid,
    output logic                ifid_ready,
    input  uop_pkg::fetch_t     ifid,
    output logic                uop_valid,
    input  logic                uop_ready,
    output uop_pkg::uop_t       uop,
    input  logic                commit_en,
    input  commit_pkg::result_t commit
);

    localparam logic [6:0] OPC_OP = 7'b0110011;

    logic [`SLICE_XLEN-1:0]  regs [`SLICE_NREGS];
    logic [`SLICE_NREGS-1:0] busy;

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [`SLICE_RIDX-1:0]  rs1;
    logic [`SLICE_RIDX-1:0]  rs2;
    logic [`SLICE_RIDX-1:0]  rd;
    logic                    is_op;
    logic                    is_shift;
    logic                    alt;
    logic [`SLICE_XLEN-1:0]  rs1_val;
    logic [`SLICE_XLEN-1:0]  rs2_val;
    logic [`SLICE_XLEN-1:0]  imm;
    logic                    hazard;
    logic                    uop_fire;
    logic                    wb_en;

    assign opcode   = ifid.instr[6:0];
    assign rd       = ifid.instr[11:7];
    assign funct3   = ifid.instr[14:12];
    assign rs1      = ifid.instr[19:15];
    assign rs2      = ifid.instr[24:20];
    assign is_op    = (opcode == OPC_OP);
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    // funct7 bit 5 selects sub only for register form, sra for both forms
    assign alt = ifid.instr[30] && ((is_op && funct3 == 3'b000) || funct3 == 3'b101);

    // x0 reads as zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // shift immediates carry only the shamt
    assign imm = is_shift ? {{(`SLICE_XLEN-5){1'b0}}, ifid.instr[24:20]}
                          : {{(`SLICE_XLEN-12){ifid.instr[31]}}, ifid.instr[31:20]};

    // raw on sources, waw on rd keeps busy clears in order
    assign hazard = busy[rs1] || (is_op && busy[rs2]) || busy[rd];

    assign uop_valid  = ifid_valid && !hazard;
    assign ifid_ready = uop_ready && !hazard;
    assign uop_fire   = uop_valid && uop_ready;
    assign wb_en      = commit_en && commit.writes_rd && !flush;

    always_comb begin
        uop.op        = uop_pkg::alu_op_e'({alt, funct3});
        uop.rd        = rd;
        uop.a         = rs1_val;
        uop.b         = is_op ? rs2_val : imm;
        uop.writes_rd = (rd != '0);
        uop.pc        = ifid.pc;
    end

    // scoreboard, a new producer wins over a commit clear
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            if (commit_en && commit.writes_rd) begin
                busy[commit.rd] <= 1'b0;
            end
            if (uop_fire && uop.writes_rd) begin
                busy[rd] <= 1'b1;
            end
        end
    end

    // architectural state, written only at commit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `SLICE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[commit.rd] <= commit.value;
        end
    end

endmodule

/* logic/issue_queue.sv */
// in-order issue queue of micro-ops, circular buffer cleared by flush
`timescale 1ns/1ns
`include "slice_params.svh"

module issue_queue (
    input  logic          clk,
    input  logic          reset,
    input  logic          flush,
    input  logic          uop_valid,
    output logic          uop_ready,
    input  uop_pkg::uop_t uop,
    output logic          iq_valid,
    input  logic          iq_ready,
    output uop_pkg::uop_t iq_uop
);

    localparam int DEPTH = `SLICE_IQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    uop_pkg::uop_t    mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign iq_valid = (count != '0);
    assign iq_uop   = mem[rd_ptr];

    // a full queue still takes a push when the head leaves
    assign uop_ready = !full || iq_ready;
    assign push      = uop_valid && uop_ready;
    assign pop       = iq_valid && iq_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= uop;
        end
    end

endmodule

/* logic/alu_exec.sv */
// alu execute stage with a result register held under back-pressure
`timescale 1ns/1ns
`include "slice_params.svh"

module alu_exec (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                iq_valid,
    output logic                iq_ready,
    input  uop_pkg::uop_t       iq_uop,
    output logic                result_valid,
    input  logic                result_ready,
    output commit_pkg::result_t result,
    output logic                commit_en,
    output commit_pkg::result_t commit
);

    logic [`SLICE_XLEN-1:0] a;
    logic [`SLICE_XLEN-1:0] b;
    logic [4:0]             shamt;
    logic [`SLICE_XLEN-1:0] value;
    logic                   pop;

    assign a     = iq_uop.a;
    assign b     = iq_uop.b;
    assign shamt = b[4:0];

    always_comb begin
        case (iq_uop.op)
            uop_pkg::op_add:  value = a + b;
            uop_pkg::op_sub:  value = a - b;
            uop_pkg::op_sll:  value = a << shamt;
            uop_pkg::op_slt:  value = {{(`SLICE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            uop_pkg::op_sltu: value = {{(`SLICE_XLEN-1){1'b0}}, a < b};
            uop_pkg::op_xor:  value = a ^ b;
            uop_pkg::op_srl:  value = a >> shamt;
            uop_pkg::op_sra:  value = $unsigned($signed(a) >>> shamt);
            uop_pkg::op_or:   value = a | b;
            uop_pkg::op_and:  value = a & b;
            default:          value = '0;
        endcase
    end

    // room when empty or when the held result is taken now
    assign iq_ready = !result_valid || result_ready;
    assign pop      = iq_valid && iq_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (flush) begin
            result_valid <= 1'b0;
        end else if (pop) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result.pc        <= iq_uop.pc;
            result.rd        <= iq_uop.rd;
            result.writes_rd <= iq_uop.writes_rd;
            result.value     <= value;
        end
    end

    // acceptance at the commit port is the commit point
    assign commit_en = result_valid && result_ready;
    assign commit    = result;

endmodule

/* logic/int_slice_top.sv */
// integer slice top: if/id register, decode, issue queue and alu execute
`timescale 1ns/1ns

module int_slice_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                fetch_valid,
    output logic                fetch_ready,
    input  uop_pkg::fetch_t     fetch,
    output logic                result_valid,
    input  logic                result_ready,
    output commit_pkg::result_t result
);

    logic                ifid_valid;
    logic                ifid_ready;
    uop_pkg::fetch_t     ifid;
    logic                uop_valid;
    logic                uop_ready;
    uop_pkg::uop_t       uop;
    logic                iq_valid;
    logic                iq_ready;
    uop_pkg::uop_t       iq_uop;
    logic                commit_en;
    commit_pkg::result_t commit;

    ifid_stage i_ifid (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .ifid_valid  (ifid_valid),
        .ifid_ready  (ifid_ready),
        .ifid        (ifid)
    );

    decode_stage i_decode (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .ifid_valid (ifid_valid),
        .ifid_ready (ifid_ready),
        .ifid       (ifid),
        .uop_valid  (uop_valid),
        .uop_ready  (uop_ready),
        .uop        (uop),
        .commit_en  (commit_en),
        .commit     (commit)
    );

    issue_queue i_iq (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .uop_valid (uop_valid),
        .uop_ready (uop_ready),
        .uop       (uop),
        .iq_valid  (iq_valid),
        .iq_ready  (iq_ready),
        .iq_uop    (iq_uop)
    );

    alu_exec i_alu (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .iq_valid     (iq_valid),
        .iq_ready     (iq_ready),
        .iq_uop       (iq_uop),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .commit_en    (commit_en),
        .commit       (commit)
    );

endmodule

/* dv/int_slice_properties.sv */
// handshake and flush checks for the integer slice, bound to the top level
`timescale 1ns/1ns
`include "slice_params.svh"

module int_slice_properties (
    input logic                clk,
    input logic                reset,
    input logic                flush,
    input logic                result_valid,
    input logic                result_ready,
    input commit_pkg::result_t result,
    input logic                uop_valid,
    input logic                uop_ready,
    input logic                iq_valid,
    input logic                iq_ready
);

    logic [3:0] occupancy;
    logic       push;
    logic       pop;

    assign push = uop_valid && uop_ready;
    assign pop  = iq_valid && iq_ready;

    // shadow count of queue entries
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            occupancy <= '0;
        end else if (flush) begin
            occupancy <= '0;
        end else if (push && !pop) begin
            occupancy <= occupancy + 1'b1;
        end else if (pop && !push) begin
            occupancy <= occupancy - 1'b1;
        end
    end

    result_hold: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready && !flush |=> result_valid && $stable(result))
        else $error("result changed or dropped before it was accepted");

    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        push && !pop && !flush |-> occupancy < 4'(`SLICE_IQ_DEPTH))
        else $error("push accepted into a full issue queue");

    flush_empties_result: assert property (@(posedge clk) disable iff (reset)
        flush |=> !result_valid)
        else $error("result_valid high in the cycle after a flush");

endmodule

bind int_slice_top int_slice_properties i_props (.*);

/* dv/int_slice_tb.sv */
// integer slice testbench: directed alu tests against a register model
`timescale 1ns/1ns
`include "slice_params.svh"

module int_slice_tb;

    // instructions sent by the six tests, with the back-pressure fill at its limit
    localparam int TOTAL_INSTR = 30 + 18 + 8 + 4 + 28 + 8;
    // {funct7, funct3} of the ten register-register ops
    localparam bit [9:0] R_OPS [10] = '{10'h000, 10'h100, 10'h001, 10'h002, 10'h003,
                                        10'h004, 10'h005, 10'h105, 10'h006, 10'h007};

    logic                clk;
    logic                reset;
    logic                flush;
    logic                fetch_valid;
    logic                fetch_ready;
    uop_pkg::fetch_t     fetch;
    logic                result_valid;
    logic                result_ready;
    commit_pkg::result_t result;

    logic [31:0]     model [`SLICE_NREGS];
    uop_pkg::fetch_t exp_q [$];
    logic [31:0]     next_pc;
    int              errors;
    int              commits;
    int              ready_mode;

    int_slice_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [9:0] f, input int rd,
                                          input int rs1, input int rs2);
        return {f[9:3], 5'(rs2), 5'(rs1), f[2:0], 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input int rd, input int rs1);
        return {imm, 5'(rs1), f3, 5'(rd), 7'h13};
    endfunction

    // expected value from the rv32i rules and the current model state
    function automatic logic [31:0] expected_value(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        reg_form;
        f3       = instr[14:12];
        reg_form = (instr[6:0] == 7'h33);
        a        = model[instr[19:15]];
        if (reg_form) begin
            b = model[instr[24:20]];
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            b = {27'b0, instr[24:20]};
        end else begin
            b = {{20{instr[31]}}, instr[31:20]};
        end
        case (f3)
            3'd0: return (reg_form && instr[30]) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return instr[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // checks each commit against the register model
    always @(posedge clk) begin
        uop_pkg::fetch_t f;
        logic [31:0]     exp_val;
        logic [4:0]      exp_rd;
        // nothing commits in a flush cycle
        if (!reset && !flush && result_valid && result_ready) begin
            commits++;
            assert (exp_q.size() != 0)
                else begin
                    $display("unexpected commit of pc %h with no instruction outstanding",
                             result.pc);
                    errors++;
                end
            if (exp_q.size() != 0) begin
                f       = exp_q.pop_front();
                exp_val = expected_value(f.instr);
                exp_rd  = f.instr[11:7];
                assert (result.pc == f.pc && result.rd == exp_rd)
                    else begin
                        $display("FAIL %0t pc/rd %h/%0d expected %h/%0d", $time,
                                 result.pc, result.rd, f.pc, exp_rd);
                        errors++;
                    end
                assert (result.writes_rd == (exp_rd != 0))
                    else begin
                        $display("FAIL %0t writes_rd wrong at pc %h", $time, f.pc);
                        errors++;
                    end
                assert (exp_rd == 0 || result.value == exp_val)
                    else begin
                        $display("FAIL %0t value %h expected %h at pc %h", $time,
                                 result.value, exp_val, f.pc);
                        errors++;
                    end
                if (exp_rd != 0) begin
                    model[exp_rd] = exp_val;
                end
            end
        end
    end

    // ready_mode 0 keeps result_ready high, 1 randomizes it and 2 holds it low
    always @(negedge clk) begin
        if (ready_mode == 1) begin
            result_ready = 1'($urandom);
        end else begin
            result_ready = (ready_mode == 0);
        end
    end

    task automatic send(input logic [31:0] instr);
        bit taken;
        taken       = 1'b0;
        fetch.instr = instr;
        fetch.pc    = next_pc;
        fetch_valid = 1'b1;
        while (!taken) begin
            @(posedge clk);
            taken = fetch_ready;
        end
        exp_q.push_back(fetch);
        next_pc += 4;
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 400) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q.size() == 0)
            else begin
                $display("%0d instructions never committed", exp_q.size());
                errors++;
                exp_q.delete();
            end
    endtask

    task automatic r_type_ops();
        for (int k = 0; k < 10; k++) begin
            send(enc_i(12'($urandom), 3'd0, 1, 0));
            send(enc_i(12'($urandom), 3'd0, 2, 0));
            send(enc_r(R_OPS[k], 3, 1, 2));
        end
        drain();
    endtask

    task automatic i_type_ops();
        logic [2:0] f3s [6];
        f3s = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        for (int k = 0; k < 6; k++) begin
            send(enc_i(12'h800 | 12'($urandom), 3'd0, 5, 0));
            send(enc_i(12'h800 | 12'($urandom), f3s[k], 6, 5));
        end
        send(enc_i(12'h800 | 12'($urandom), 3'd0, 5, 0));
        send(enc_i({7'h00, 5'($urandom)}, 3'd1, 6, 5));
        send(enc_i(12'h800 | 12'($urandom), 3'd0, 5, 0));
        send(enc_i({7'h00, 5'($urandom)}, 3'd5, 6, 5));
        send(enc_i(12'h800 | 12'($urandom), 3'd0, 5, 0));
        send(enc_i({7'h20, 5'($urandom)}, 3'd5, 6, 5));
        drain();
    endtask

    task automatic dependent_chain();
        send(enc_i(12'($urandom), 3'd0, 6, 0));
        for (int i = 1; i < 8; i++) begin
            if (i % 2 == 1) begin
                send(enc_i(12'($urandom), 3'd0, 6 + i, 5 + i));
            end else begin
                send(enc_r(10'h000, 6 + i, 5 + i, 5 + i));
            end
        end
        drain();
    endtask

    task automatic x0_writes();
        send(enc_i(12'd123, 3'd0, 0, 0));
        send(enc_r(10'h000, 0, 1, 2));
        send(enc_r(10'h000, 15, 0, 0));
        send(enc_i(12'd5, 3'd0, 16, 0));
        drain();
    endtask

    task automatic backpressure_order();
        bit stalled;
        ready_mode <= 1;
        for (int i = 0; i < 12; i++) begin
            send(enc_i(12'($urandom), 3'd0, 1 + i % 8, 0));
        end
        ready_mode <= 2;
        stalled = 1'b0;
        for (int i = 0; i < 16 && !stalled; i++) begin
            fetch.instr = enc_i(12'($urandom), 3'd0, 17 + i, 0);
            fetch.pc    = next_pc;
            fetch_valid = 1'b1;
            @(posedge clk);
            if (fetch_ready) begin
                exp_q.push_back(fetch);
                next_pc += 4;
            end else begin
                stalled = 1'b1;
            end
            @(negedge clk);
        end
        fetch_valid = 1'b0;
        assert (stalled)
            else begin
                $display("fetch_ready never fell while result_ready was held low");
                errors++;
            end
        ready_mode <= 0;
        drain();
    endtask

    task automatic flush_in_flight();
        send(enc_i(12'd77, 3'd0, 10, 0));
        send(enc_i(12'd91, 3'd0, 11, 0));
        drain();
        ready_mode <= 2;
        for (int i = 0; i < 4; i++) begin
            send(enc_i(12'($urandom), 3'd0, 10 + i, 0));
        end
        repeat (3) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        // the squashed instructions never commit
        exp_q.delete();
        ready_mode <= 0;
        repeat (6) @(negedge clk);
        send(enc_r(10'h000, 14, 10, 11));
        send(enc_r(10'h100, 15, 14, 12));
        drain();
    endtask

    initial begin
        errors  = 0;
        commits = 0;
        next_pc = 32'h0000_1000;
        for (int i = 0; i < `SLICE_NREGS; i++) begin
            model[i] = '0;
        end
        void'($urandom(32'h1dcf38f8));
        ready_mode   = 0;
        reset        = 1'b1;
        flush        = 1'b0;
        fetch_valid  = 1'b0;
        fetch        = '0;
        result_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        r_type_ops();
        i_type_ops();
        dependent_chain();
        x0_writes();
        backpressure_order();
        flush_in_flight();
        repeat (4) @(negedge clk);
        $display("commits: %0d errors: %0d", commits, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog allows 40 cycles of 100 ns per instruction
    initial begin
        #(TOTAL_INSTR * 40 * 100);
        $display("watchdog timeout, the tests did not finish");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
logic/uop_pkg.sv
logic/commit_pkg.sv
logic/ifid_stage.sv
logic/decode_stage.sv
logic/issue_queue.sv
logic/alu_exec.sv
logic/int_slice_top.sv
dv/int_slice_properties.sv
dv/int_slice_tb.sv

/* run.sh */
#!/bin/sh
# build and run the integer slice testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module int_slice_tb -o sim_int_slice
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_int_slice > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "no result line in the log"
    exit 1
fi
exit 0
